// File: hw/vi_pkg.sv
// data width is fixed at 32 bits; opcode 3'b111 is unused and behaves like a no-result op

package vi_pkg;

	localparam int VI_XLEN = 32;

	// integer word, also used for the pc
	typedef logic [VI_XLEN-1:0] vi_data_t;

	// register index, 32 entries
	typedef logic [4:0] vi_reg_t;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		// signed compare, result 1 or 0
		SLT = 3'd5,
		// goes to the multiplier, never to the alu
		MUL = 3'd6
	} vi_op_e;

endpackage

// File: hw/vi_regfile.sv
// reads are combinational and do not see a write of the same cycle; x0 always reads zero
`timescale 1ns/10ps

module vi_regfile import vi_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	input  vi_reg_t  rd_addr_a_i,
	input  vi_reg_t  rd_addr_b_i,
	output vi_data_t rd_data_a_o,
	output vi_data_t rd_data_b_o,
	input  logic     wr_en_i,
	input  vi_reg_t  wr_addr_i,
	input  vi_data_t wr_data_i
);

	vi_data_t regs [32];

	assign rd_data_a_o = regs[rd_addr_a_i];
	assign rd_data_b_o = regs[rd_addr_b_i];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			// x0 never written, so entry 0 stays zero
			regs[wr_addr_i] <= wr_data_i;
		end
	end

endmodule

// File: hw/vi_alu.sv
// purely combinational; MUL and the unused opcode give zero, the multiplier produces MUL results
`timescale 1ns/10ps

module vi_alu import vi_pkg::*; (
	input  vi_op_e   op_i,
	input  vi_data_t data_a_i,
	input  vi_data_t data_b_i,
	output vi_data_t result_o
);

	logic lt_signed;

	assign lt_signed = $signed(data_a_i) < $signed(data_b_i);

	always_comb begin
		case (op_i)
			ADD: result_o = data_a_i + data_b_i;
			SUB: result_o = data_a_i - data_b_i;
			AND: result_o = data_a_i & data_b_i;
			OR:  result_o = data_a_i | data_b_i;
			XOR: result_o = data_a_i ^ data_b_i;
			SLT: result_o = {{(VI_XLEN-1){1'b0}}, lt_signed};
			default: result_o = '0;
		endcase
	end

endmodule

// File: hw/vi_bypass_ctrl.sv
// stage vectors are packed with stage 1 at bit 0; the top entry is the final multiply stage
`timescale 1ns/10ps

module vi_bypass_ctrl import vi_pkg::*; #(
	parameter int NUM_MULT_STAGES = 4
) (
	input  vi_reg_t                                   rs1_i,
	input  vi_reg_t                                   rs2_i,
	input  vi_reg_t                                   rd_i,
	input  logic                                      is_alu_i,
	input  logic                                      exe_valid_i,
	input  logic                                      exe_is_mul_i,
	input  vi_reg_t                                   exe_rd_i,
	input  vi_data_t                                  exe_data_i,
	input  logic [NUM_MULT_STAGES-1:0]                stage_valid_i,
	input  logic [NUM_MULT_STAGES*$bits(vi_reg_t)-1:0] stage_rd_i,
	input  vi_data_t                                  last_data_i,
	input  logic                                      wb_valid_i,
	input  vi_reg_t                                   wb_rd_i,
	input  vi_data_t                                  wb_data_i,
	input  vi_data_t                                  reg_a_i,
	input  vi_data_t                                  reg_b_i,
	output vi_data_t                                  operand_a_o,
	output vi_data_t                                  operand_b_o,
	output logic                                      hazard_o
);

	localparam int RW = $bits(vi_reg_t);

	logic    last_valid;
	vi_reg_t last_rd;
	logic    pre_last_mul;
	logic    raw_hazard;
	logic    waw_hazard;

	assign last_valid = stage_valid_i[NUM_MULT_STAGES-1];
	assign last_rd    = stage_rd_i[(NUM_MULT_STAGES-1)*RW +: RW];

	// youngest producer wins
	function automatic vi_data_t select_operand(input vi_reg_t rs, input vi_data_t reg_val);
		vi_data_t sel;
		sel = reg_val;
		if (rs == '0) begin
			sel = '0;
		end else if (exe_valid_i && !exe_is_mul_i && (exe_rd_i == rs)) begin
			sel = exe_data_i;
		end else if (last_valid && (last_rd == rs)) begin
			sel = last_data_i;
		end else if (wb_valid_i && (wb_rd_i == rs)) begin
			sel = wb_data_i;
		end
		return sel;
	endfunction

	function automatic logic src_match(input vi_reg_t r);
		return ((rs1_i != '0) && (rs1_i == r)) || ((rs2_i != '0) && (rs2_i == r));
	endfunction

	always_comb begin
		operand_a_o = select_operand(rs1_i, reg_a_i);
		operand_b_o = select_operand(rs2_i, reg_b_i);
	end

	always_comb begin
		vi_reg_t st_rd;
		raw_hazard = 1'b0;
		waw_hazard = 1'b0;
		if (exe_valid_i && exe_is_mul_i) begin
			raw_hazard = src_match(exe_rd_i);
			waw_hazard = (exe_rd_i == rd_i);
		end
		for (int i = 0; i < NUM_MULT_STAGES; i++) begin
			st_rd = stage_rd_i[i*RW +: RW];
			if (stage_valid_i[i]) begin
				// only the final stage product can be forwarded
				if ((i < NUM_MULT_STAGES-1) && src_match(st_rd)) begin
					raw_hazard = 1'b1;
				end
				if (st_rd == rd_i) begin
					waw_hazard = 1'b1;
				end
			end
		end
	end

	// a MUL one step away from the last stage would reach writeback with this alu op
	if (NUM_MULT_STAGES == 1) begin : g_pre_last_exe
		assign pre_last_mul = exe_valid_i && exe_is_mul_i;
	end else begin : g_pre_last_stage
		assign pre_last_mul = stage_valid_i[NUM_MULT_STAGES-2];
	end

	assign hazard_o = raw_hazard || waw_hazard || (is_alu_i && pre_last_mul);

endmodule

// File: hw/vi_issue.sv
// upstream must hold its instruction while stall_o is high; one instruction accepted per cycle
`timescale 1ns/10ps

module vi_issue import vi_pkg::*; #(
	parameter int NUM_MULT_STAGES = 4
) (
	input  logic                                      clk_i,
	input  logic                                      rst_i,
	input  logic                                      instr_valid_i,
	input  vi_op_e                                    instr_op_i,
	input  vi_reg_t                                   instr_rs1_i,
	input  vi_reg_t                                   instr_rs2_i,
	input  vi_reg_t                                   instr_rd_i,
	input  vi_data_t                                  instr_pc_i,
	output logic                                      stall_o,
	output vi_reg_t                                   rf_addr_a_o,
	output vi_reg_t                                   rf_addr_b_o,
	input  vi_data_t                                  rf_data_a_i,
	input  vi_data_t                                  rf_data_b_i,
	output logic                                      exe_valid_o,
	output vi_op_e                                    exe_op_o,
	output vi_reg_t                                   exe_rd_o,
	output vi_data_t                                  exe_pc_o,
	output vi_data_t                                  exe_a_o,
	output vi_data_t                                  exe_b_o,
	input  logic [NUM_MULT_STAGES-1:0]                stage_valid_i,
	input  logic [NUM_MULT_STAGES*$bits(vi_reg_t)-1:0] stage_rd_i,
	input  vi_data_t                                  last_data_i,
	input  vi_data_t                                  alu_result_i,
	input  logic                                      wb_valid_i,
	input  vi_reg_t                                   wb_rd_i,
	input  vi_data_t                                  wb_data_i
);

	logic     hazard;
	logic     accept;
	vi_data_t operand_a;
	vi_data_t operand_b;

	assign rf_addr_a_o = instr_rs1_i;
	assign rf_addr_b_o = instr_rs2_i;

	vi_bypass_ctrl #(
		.NUM_MULT_STAGES (NUM_MULT_STAGES)
	) bypass_ctrl (
		.rs1_i         (instr_rs1_i),
		.rs2_i         (instr_rs2_i),
		.rd_i          (instr_rd_i),
		.is_alu_i      (instr_op_i != MUL),
		.exe_valid_i   (exe_valid_o),
		.exe_is_mul_i  (exe_op_o == MUL),
		.exe_rd_i      (exe_rd_o),
		.exe_data_i    (alu_result_i),
		.stage_valid_i (stage_valid_i),
		.stage_rd_i    (stage_rd_i),
		.last_data_i   (last_data_i),
		.wb_valid_i    (wb_valid_i),
		.wb_rd_i       (wb_rd_i),
		.wb_data_i     (wb_data_i),
		.reg_a_i       (rf_data_a_i),
		.reg_b_i       (rf_data_b_i),
		.operand_a_o   (operand_a),
		.operand_b_o   (operand_b),
		.hazard_o      (hazard)
	);

	assign stall_o = instr_valid_i && hazard;
	assign accept  = instr_valid_i && !hazard;

	// execute latch
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			exe_valid_o <= 1'b0;
			exe_op_o    <= ADD;
			exe_rd_o    <= '0;
			exe_pc_o    <= '0;
			exe_a_o     <= '0;
			exe_b_o     <= '0;
		end else begin
			// a bubble enters execute whenever nothing is accepted
			exe_valid_o <= accept;
			if (accept) begin
				exe_op_o <= instr_op_i;
				exe_rd_o <= instr_rd_i;
				exe_pc_o <= instr_pc_i;
				exe_a_o  <= operand_a;
				exe_b_o  <= operand_b;
			end
		end
	end

endmodule

// File: hw/vi_mult_stage.sv
// NUM_MULT_STAGES must divide 32; STAGE_INDEX counts from 0 and selects the slice of b
`timescale 1ns/10ps

module vi_mult_stage import vi_pkg::*; #(
	parameter int NUM_MULT_STAGES = 4,
	parameter int STAGE_INDEX     = 0
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     valid_i,
	input  vi_reg_t  rd_i,
	input  vi_data_t pc_i,
	input  vi_data_t a_i,
	input  vi_data_t b_i,
	input  vi_data_t prod_i,
	output logic     valid_o,
	output vi_reg_t  rd_o,
	output vi_data_t pc_o,
	output vi_data_t a_o,
	output vi_data_t b_o,
	output vi_data_t prod_o
);

	localparam int SLICE = VI_XLEN / NUM_MULT_STAGES;
	localparam int LSB   = STAGE_INDEX * SLICE;

	vi_data_t b_slice;
	vi_data_t partial;

	// upper bits of the product fall off, result is modulo 2^32
	assign b_slice = VI_XLEN'(b_i[LSB +: SLICE]);
	assign partial = (a_i * b_slice) << LSB;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			rd_o    <= '0;
			pc_o    <= '0;
			a_o     <= '0;
			b_o     <= '0;
			prod_o  <= '0;
		end else begin
			valid_o <= valid_i;
			rd_o    <= rd_i;
			pc_o    <= pc_i;
			a_o     <= a_i;
			b_o     <= b_i;
			prod_o  <= prod_i + partial;
		end
	end

endmodule

// File: hw/vi_writeback.sv
// alu and multiplier must never complete in the same cycle; the issue stage guarantees it
`timescale 1ns/10ps

module vi_writeback import vi_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     exe_valid_i,
	input  vi_op_e   exe_op_i,
	input  vi_reg_t  exe_rd_i,
	input  vi_data_t exe_pc_i,
	input  vi_data_t alu_result_i,
	input  logic     last_valid_i,
	input  vi_reg_t  last_rd_i,
	input  vi_data_t last_pc_i,
	input  vi_data_t last_prod_i,
	output logic     wr_en_o,
	output vi_reg_t  wr_addr_o,
	output vi_data_t wr_data_o,
	output logic     ret_valid_o,
	output vi_reg_t  ret_rd_o,
	output vi_data_t ret_data_o,
	output vi_data_t ret_pc_o
);

	logic     alu_done;
	logic     wb_valid;
	vi_reg_t  wb_rd;
	vi_data_t wb_data;
	vi_data_t wb_pc;

	assign alu_done = exe_valid_i && (exe_op_i != MUL);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
			wb_pc    <= '0;
		end else begin
			wb_valid <= alu_done || last_valid_i;
			if (alu_done) begin
				wb_rd   <= exe_rd_i;
				wb_data <= alu_result_i;
				wb_pc   <= exe_pc_i;
			end else if (last_valid_i) begin
				wb_rd   <= last_rd_i;
				wb_data <= last_prod_i;
				wb_pc   <= last_pc_i;
			end
		end
	end

	// x0 retires but is never written
	assign wr_en_o   = wb_valid && (wb_rd != '0);
	assign wr_addr_o = wb_rd;
	assign wr_data_o = wb_data;

	assign ret_valid_o = wb_valid;
	assign ret_rd_o    = wb_rd;
	assign ret_data_o  = wb_data;
	assign ret_pc_o    = wb_pc;

endmodule

// File: hw/vi_exec_top.sv
// NUM_MULT_STAGES may be 1, 2, 4 or 8; retire has no back-pressure and must always be taken
`timescale 1ns/10ps

module vi_exec_top import vi_pkg::*; #(
	parameter int NUM_MULT_STAGES = 4
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     instr_valid_i,
	input  vi_op_e   instr_op_i,
	input  vi_reg_t  instr_rs1_i,
	input  vi_reg_t  instr_rs2_i,
	input  vi_reg_t  instr_rd_i,
	input  vi_data_t instr_pc_i,
	output logic     stall_o,
	output logic     ret_valid_o,
	output vi_reg_t  ret_rd_o,
	output vi_data_t ret_data_o,
	output vi_data_t ret_pc_o
);

	localparam int RW = $bits(vi_reg_t);

	vi_reg_t  rf_addr_a;
	vi_reg_t  rf_addr_b;
	vi_data_t rf_data_a;
	vi_data_t rf_data_b;
	logic     wr_en;
	vi_reg_t  wr_addr;
	vi_data_t wr_data;

	logic     exe_valid;
	vi_op_e   exe_op;
	vi_reg_t  exe_rd;
	vi_data_t exe_pc;
	vi_data_t exe_a;
	vi_data_t exe_b;
	vi_data_t alu_result;

	// entry 0 is the execute latch, entry k is the output of stage k
	logic [NUM_MULT_STAGES:0] chain_valid;
	vi_reg_t                  chain_rd   [NUM_MULT_STAGES+1];
	vi_data_t                 chain_pc   [NUM_MULT_STAGES+1];
	vi_data_t                 chain_a    [NUM_MULT_STAGES+1];
	vi_data_t                 chain_b    [NUM_MULT_STAGES+1];
	vi_data_t                 chain_prod [NUM_MULT_STAGES+1];

	logic [NUM_MULT_STAGES-1:0]    stage_valid;
	logic [NUM_MULT_STAGES*RW-1:0] stage_rd;

	vi_regfile regfile (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.rd_addr_a_i (rf_addr_a),
		.rd_addr_b_i (rf_addr_b),
		.rd_data_a_o (rf_data_a),
		.rd_data_b_o (rf_data_b),
		.wr_en_i     (wr_en),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data)
	);

	vi_issue #(
		.NUM_MULT_STAGES (NUM_MULT_STAGES)
	) issue (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.instr_valid_i (instr_valid_i),
		.instr_op_i    (instr_op_i),
		.instr_rs1_i   (instr_rs1_i),
		.instr_rs2_i   (instr_rs2_i),
		.instr_rd_i    (instr_rd_i),
		.instr_pc_i    (instr_pc_i),
		.stall_o       (stall_o),
		.rf_addr_a_o   (rf_addr_a),
		.rf_addr_b_o   (rf_addr_b),
		.rf_data_a_i   (rf_data_a),
		.rf_data_b_i   (rf_data_b),
		.exe_valid_o   (exe_valid),
		.exe_op_o      (exe_op),
		.exe_rd_o      (exe_rd),
		.exe_pc_o      (exe_pc),
		.exe_a_o       (exe_a),
		.exe_b_o       (exe_b),
		.stage_valid_i (stage_valid),
		.stage_rd_i    (stage_rd),
		.last_data_i   (chain_prod[NUM_MULT_STAGES]),
		.alu_result_i  (alu_result),
		.wb_valid_i    (ret_valid_o),
		.wb_rd_i       (ret_rd_o),
		.wb_data_i     (ret_data_o)
	);

	vi_alu alu (
		.op_i     (exe_op),
		.data_a_i (exe_a),
		.data_b_i (exe_b),
		.result_o (alu_result)
	);

	assign chain_valid[0] = exe_valid && (exe_op == MUL);
	assign chain_rd[0]    = exe_rd;
	assign chain_pc[0]    = exe_pc;
	assign chain_a[0]     = exe_a;
	assign chain_b[0]     = exe_b;
	assign chain_prod[0]  = '0;

	assign stage_valid = chain_valid[NUM_MULT_STAGES:1];

	for (genvar i = 0; i < NUM_MULT_STAGES; i++) begin : g_mult
		vi_mult_stage #(
			.NUM_MULT_STAGES (NUM_MULT_STAGES),
			.STAGE_INDEX     (i)
		) mult_stage (
			.clk_i   (clk_i),
			.rst_i   (rst_i),
			.valid_i (chain_valid[i]),
			.rd_i    (chain_rd[i]),
			.pc_i    (chain_pc[i]),
			.a_i     (chain_a[i]),
			.b_i     (chain_b[i]),
			.prod_i  (chain_prod[i]),
			.valid_o (chain_valid[i+1]),
			.rd_o    (chain_rd[i+1]),
			.pc_o    (chain_pc[i+1]),
			.a_o     (chain_a[i+1]),
			.b_o     (chain_b[i+1]),
			.prod_o  (chain_prod[i+1])
		);

		assign stage_rd[i*RW +: RW] = chain_rd[i+1];
	end

	vi_writeback writeback (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.exe_valid_i  (exe_valid),
		.exe_op_i     (exe_op),
		.exe_rd_i     (exe_rd),
		.exe_pc_i     (exe_pc),
		.alu_result_i (alu_result),
		.last_valid_i (chain_valid[NUM_MULT_STAGES]),
		.last_rd_i    (chain_rd[NUM_MULT_STAGES]),
		.last_pc_i    (chain_pc[NUM_MULT_STAGES]),
		.last_prod_i  (chain_prod[NUM_MULT_STAGES]),
		.wr_en_o      (wr_en),
		.wr_addr_o    (wr_addr),
		.wr_data_o    (wr_data),
		.ret_valid_o  (ret_valid_o),
		.ret_rd_o     (ret_rd_o),
		.ret_data_o   (ret_data_o),
		.ret_pc_o     (ret_pc_o)
	);

endmodule

// File: tests/vi_exec_sva.sv
// bound into vi_exec_top; NUM_MULT_STAGES follows the top level and the clock must run through reset
`timescale 1ns/10ps

module vi_exec_sva import vi_pkg::*; #(
	parameter int NUM_MULT_STAGES = 4
) (
	input logic                       clk_i,
	input logic                       rst_i,
	input logic                       instr_valid_i,
	input logic                       stall_i,
	input logic                       exe_valid_i,
	input vi_op_e                     exe_op_i,
	input logic [NUM_MULT_STAGES-1:0] stage_valid_i,
	input logic                       ret_valid_i
);

	int   fail_count = 0;
	logic alu_done;

	assign alu_done = exe_valid_i && (exe_op_i != MUL);

	// sync reset clears every valid by the next edge
	reset_clears_valids: assert property (@(posedge clk_i)
		rst_i |=> (stage_valid_i == '0) && !exe_valid_i && !ret_valid_i)
	else begin
		$error("valid bit still set after a reset edge");
		fail_count++;
	end

	quiet_after_reset: assert property (@(posedge clk_i)
		$fell(rst_i) |-> !ret_valid_i && !stall_i)
	else begin
		$error("retire or stall active right after reset");
		fail_count++;
	end

	// both paths into writeback at once would lose a result
	single_completion: assert property (@(posedge clk_i) disable iff (rst_i)
		!(alu_done && stage_valid_i[NUM_MULT_STAGES-1]))
	else begin
		$error("alu and last multiply stage complete together");
		fail_count++;
	end

	stall_needs_valid: assert property (@(posedge clk_i)
		stall_i |-> instr_valid_i)
	else begin
		$error("stall raised without a presented instruction");
		fail_count++;
	end

endmodule

bind vi_exec_top vi_exec_sva #(
	.NUM_MULT_STAGES (NUM_MULT_STAGES)
) sva (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.instr_valid_i (instr_valid_i),
	.stall_i       (stall_o),
	.exe_valid_i   (exe_valid),
	.exe_op_i      (exe_op),
	.stage_valid_i (stage_valid),
	.ret_valid_i   (ret_valid_o)
);

// File: tests/vi_exec_tb.sv
// NUM_MULT_STAGES must match the DUT; x31 is reserved for loading values through a forced read port
`timescale 1ns/10ps

module vi_exec_tb import vi_pkg::*; ();

	localparam int NUM_MULT_STAGES = 4;
	localparam int NUM_INSTR       = 400;
	localparam int NUM_SEEDS       = 7;
	localparam int CLK_PERIOD      = 100;
	localparam longint WATCHDOG_NS = (NUM_INSTR * (NUM_MULT_STAGES + 3) + 16) * CLK_PERIOD;

	logic     clk_i;
	logic     rst_i;
	logic     instr_valid_i;
	vi_op_e   instr_op_i;
	vi_reg_t  instr_rs1_i;
	vi_reg_t  instr_rs2_i;
	vi_reg_t  instr_rd_i;
	vi_data_t instr_pc_i;
	logic     stall_o;
	logic     ret_valid_o;
	vi_reg_t  ret_rd_o;
	vi_data_t ret_data_o;
	vi_data_t ret_pc_o;

	// register model in program order
	vi_data_t model_regs [32];
	// per-instruction expectations indexed by pc / 4
	vi_data_t exp_data   [NUM_INSTR];
	vi_reg_t  exp_rd     [NUM_INSTR];
	int       exp_lat    [NUM_INSTR];
	int       acc_cycle  [NUM_INSTR];
	bit       pending    [NUM_INSTR];
	vi_data_t seed_word;
	int       next_idx = 0;
	int       retired  = 0;
	int       cycle    = 0;

	vi_exec_top #(
		.NUM_MULT_STAGES (NUM_MULT_STAGES)
	) dut (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.instr_valid_i (instr_valid_i),
		.instr_op_i    (instr_op_i),
		.instr_rs1_i   (instr_rs1_i),
		.instr_rs2_i   (instr_rs2_i),
		.instr_rd_i    (instr_rd_i),
		.instr_pc_i    (instr_pc_i),
		.stall_o       (stall_o),
		.ret_valid_o   (ret_valid_o),
		.ret_rd_o      (ret_rd_o),
		.ret_data_o    (ret_data_o),
		.ret_pc_o      (ret_pc_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle <= cycle + 1;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic vi_data_t expected_result(input vi_op_e op, input vi_data_t a,
						     input vi_data_t b);
		logic [63:0] prod;
		prod = {32'b0, a} * {32'b0, b};
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR:  return a | b;
			XOR: return a ^ b;
			SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			MUL: return prod[31:0];
			default: return '0;
		endcase
	endfunction

	// mostly the low registers so dependencies are frequent
	function automatic vi_reg_t pick_reg();
		if ($urandom_range(0, 9) < 8) begin
			return vi_reg_t'($urandom_range(0, 7));
		end
		return vi_reg_t'($urandom_range(0, 30));
	endfunction

	function automatic vi_data_t seed_value();
		case ($urandom_range(0, 7))
			0: return 32'h8000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h7fff_ffff;
			default: return $urandom();
		endcase
	endfunction

	// called on a rising edge and returns on the edge that accepted the instruction
	task automatic issue_instr(input vi_op_e op, input vi_reg_t rs1, input vi_reg_t rs2,
				   input vi_reg_t rd, input bit seed, input vi_data_t seed_val);
		vi_data_t a;
		vi_data_t b;
		vi_data_t res;
		instr_valid_i <= 1'b1;
		instr_op_i    <= op;
		instr_rs1_i   <= rs1;
		instr_rs2_i   <= rs2;
		instr_rd_i    <= rd;
		instr_pc_i    <= vi_data_t'(next_idx * 4);
		if (seed) begin
			// stands in for a load immediate, which this back end lacks
			seed_word = seed_val;
			@(negedge clk_i);
			force dut.rf_data_a = seed_word;
		end
		do begin
			@(posedge clk_i);
		end while (stall_o !== 1'b0);
		a = (rs1 == '0) ? '0 : (seed ? seed_val : model_regs[rs1]);
		b = (rs2 == '0) ? '0 : model_regs[rs2];
		res = expected_result(op, a, b);
		exp_data[next_idx]  = res;
		exp_rd[next_idx]    = rd;
		exp_lat[next_idx]   = (op == MUL) ? NUM_MULT_STAGES + 1 : 1;
		acc_cycle[next_idx] = cycle;
		pending[next_idx]   = 1'b1;
		if (rd != '0) begin
			model_regs[rd] = res;
		end
		next_idx++;
		if (seed) begin
			instr_valid_i <= 1'b0;
			@(negedge clk_i);
			release dut.rf_data_a;
			@(posedge clk_i);
		end
	endtask

	// retire and reset checks
	always @(posedge clk_i) begin
		int idx;
		int lat;
		if (rst_i) begin
			if (cycle > 0) begin
				assert (ret_valid_o === 1'b0) else
					fail_run($sformatf("** Error ret_valid_o expected 0 actual %h", ret_valid_o));
				assert (stall_o === 1'b0) else
					fail_run($sformatf("** Error stall_o expected 0 actual %h", stall_o));
			end
		end else begin
			assert (dut.sva.fail_count == 0) else
				fail_run("a bound pipeline assertion fired");
			if (ret_valid_o === 1'b1) begin
				idx = int'(ret_pc_o >> 2);
				assert ((ret_pc_o[1:0] == 2'b00) && (idx < NUM_INSTR) && pending[idx]) else
					fail_run($sformatf("retire with pc %h that is not pending", ret_pc_o));
				assert (ret_rd_o === exp_rd[idx]) else
					fail_run($sformatf("** Error ret_rd_o expected %h actual %h",
						exp_rd[idx], ret_rd_o));
				assert (ret_data_o === exp_data[idx]) else
					fail_run($sformatf("** Error ret_data_o expected %h actual %h",
						exp_data[idx], ret_data_o));
				lat = cycle - acc_cycle[idx] - 1;
				assert (lat == exp_lat[idx]) else
					fail_run($sformatf("pc %h retired %0d cycles after acceptance, not %0d",
						ret_pc_o, lat, exp_lat[idx]));
				pending[idx] = 1'b0;
				retired++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run($sformatf("watchdog expired with %0d of %0d retired", retired, NUM_INSTR));
	end

	initial begin
		vi_op_e      op;
		vi_reg_t     rd;
		int unsigned kind;
		void'($urandom(10));
		rst_i         = 1'b1;
		instr_valid_i = 1'b0;
		instr_op_i    = ADD;
		instr_rs1_i   = '0;
		instr_rs2_i   = '0;
		instr_rd_i    = '0;
		instr_pc_i    = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < NUM_INSTR; i++) begin
			pending[i] = 1'b0;
		end
		repeat (16) @(posedge clk_i);
		rst_i <= 1'b0;
		@(posedge clk_i);
		for (int i = 1; i <= NUM_SEEDS; i++) begin
			issue_instr(ADD, 5'd31, 5'd0, vi_reg_t'(i), 1'b1, seed_value());
		end
		while (next_idx < NUM_INSTR) begin
			kind = $urandom_range(0, 9);
			rd = pick_reg();
			if (kind == 9) begin
				issue_instr(ADD, 5'd31, 5'd0, rd, 1'b1, seed_value());
			end else begin
				op = (kind < 6) ? vi_op_e'(kind) : MUL;
				issue_instr(op, pick_reg(), pick_reg(), rd, 1'b0, '0);
			end
		end
		instr_valid_i <= 1'b0;
		wait (retired == NUM_INSTR);
		repeat (NUM_MULT_STAGES + 4) @(posedge clk_i);
		if (dut.sva.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			fail_run("a bound pipeline assertion fired near the end of the run");
		end
	end

endmodule

// File: all.f
hw/vi_pkg.sv
hw/vi_regfile.sv
hw/vi_alu.sv
hw/vi_bypass_ctrl.sv
hw/vi_issue.sv
hw/vi_mult_stage.sv
hw/vi_writeback.sv
hw/vi_exec_top.sv
tests/vi_exec_sva.sv
tests/vi_exec_tb.sv
